// ==== src.f ====
rtl/aes_key_pkg.sv
rtl/aes_tables_pkg.sv
rtl/aes_sub_rot_word.sv
rtl/aes_key_state.sv
rtl/aes_round_counter.sv
rtl/aes_key_fsm.sv
rtl/aes_key_expand.sv
sim/aes_key_checker.sv
sim/tb_aes_key_expand.sv

// ==== Bender.yml ====
package:
  name: aes_key_expand

sources:
  - files:
      - rtl/aes_key_pkg.sv
      - rtl/aes_tables_pkg.sv
      - rtl/aes_sub_rot_word.sv
      - rtl/aes_key_state.sv
      - rtl/aes_round_counter.sv
      - rtl/aes_key_fsm.sv
      - rtl/aes_key_expand.sv
  - target: simulation
    files:
      - sim/aes_key_checker.sv
      - sim/tb_aes_key_expand.sv

// ==== sim/tb_aes_key_expand.sv ====
`timescale 1ns/1ps
module tb_aes_key_expand;

  localparam int NUM_KEYS       = aes_key_pkg::NUM_ROUNDS + 1;
  localparam int RANDOM_REQS    = 20;
  localparam int TIMEOUT_CYCLES = 64;
  localparam int SEL_RK_REQ     = 0;
  localparam int SEL_KEY_ACK    = 1;

  localparam logic [127:0] FIPS_KEY  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam logic [127:0] FIPS_RK10 = 128'hd014f9a8c9ee2589e13f0cc8b6630ca6;

  typedef logic [0:aes_key_pkg::NUM_ROUNDS][aes_key_pkg::KEY_W-1:0] sched_t;

  logic                          clk   = 1'b0;
  logic                          rst_n = 1'b0;
  logic                          key_req;
  logic [aes_key_pkg::KEY_W-1:0] key;
  logic                          key_ack;
  logic                          rk_req;
  logic                          rk_ack;
  logic [aes_key_pkg::KEY_W-1:0] rk_key;
  aes_key_pkg::round_t           rk_round;

  integer seed;
  int     tb_errors;
  int     check_errors;
  int     keys_checked;
  bit     stalled;
  sched_t exp_keys;

  always #4 clk = ~clk;

  aes_key_expand UUT (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .key_req_i  (key_req),
    .key_i      (key),
    .key_ack_o  (key_ack),
    .rk_req_o   (rk_req),
    .rk_ack_i   (rk_ack),
    .rk_key_o   (rk_key),
    .rk_round_o (rk_round)
  );

  aes_key_checker u_checker (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .key_req_i      (key_req),
    .key_i          (key),
    .key_ack_i      (key_ack),
    .rk_req_i       (rk_req),
    .rk_ack_i       (rk_ack),
    .rk_key_i       (rk_key),
    .rk_round_i     (rk_round),
    .exp_keys_i     (exp_keys),
    .error_count_o  (check_errors),
    .keys_checked_o (keys_checked)
  );

  // FIPS-197 key expansion, written out word by word.
  function automatic sched_t expand_ref(input logic [127:0] cipher_key);
    logic [31:0] w [0:43];
    logic [31:0] t;
    logic [7:0]  rc;
    sched_t      sched;
    rc = 8'h01;
    for (int i = 0; i < 4; i++) begin
      w[i] = cipher_key[127-32*i -: 32];
    end
    for (int i = 4; i < 44; i++) begin
      t = w[i-1];
      if (i % 4 == 0) begin
        t = {t[23:0], t[31:24]};
        t = {aes_tables_pkg::SBOX[t[31:24]], aes_tables_pkg::SBOX[t[23:16]],
             aes_tables_pkg::SBOX[t[15:8]], aes_tables_pkg::SBOX[t[7:0]]};
        t = t ^ {rc, 24'h000000};
        rc = {rc[6:0], 1'b0} ^ (rc[7] ? 8'h1b : 8'h00); // Doubling in GF(2^8).
      end
      w[i] = w[i-4] ^ t;
    end
    for (int r = 0; r < NUM_KEYS; r++) begin
      sched[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
    end
    return sched;
  endfunction

  function automatic logic [127:0] next_random_key();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic wait_for_level(input int sel, input logic level, input string what,
                                output bit ok);
    int   cycles;
    logic value;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      value = (sel == SEL_RK_REQ) ? rk_req : key_ack;
      ok    = (value === level);
      cycles++;
    end
    if (!ok) begin
      $display("Timeout at %0t: %s stalled, it did not go to %0b within %0d cycles.",
               $time, what, level, TIMEOUT_CYCLES);
      tb_errors++;
      stalled = 1'b1;
    end
  endtask

  // Called on a rising edge, so a new request follows the previous one directly.
  task automatic run_request(input logic [127:0] new_key);
    int delay;
    bit ok;
    key      <= new_key;
    exp_keys <= expand_ref(new_key);
    key_req  <= 1'b1;
    for (int r = 0; r < NUM_KEYS; r++) begin
      wait_for_level(SEL_RK_REQ, 1'b1, "the round-key handshake (request rise)", ok);
      if (!ok) return;
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) @(posedge clk);
      rk_ack <= 1'b1;
      wait_for_level(SEL_RK_REQ, 1'b0, "the round-key handshake (request fall)", ok);
      rk_ack <= 1'b0;
      if (!ok) return;
    end
    wait_for_level(SEL_KEY_ACK, 1'b1, "the key handshake (acknowledge rise)", ok);
    if (!ok) return;
    key_req <= 1'b0;
    wait_for_level(SEL_KEY_ACK, 1'b0, "the key handshake (acknowledge fall)", ok);
  endtask

  initial begin
    sched_t       ref_sched;
    logic [127:0] rand_key;
    seed      = 32'h0b13_4c37;
    key_req   = 1'b0;
    key       = '0;
    rk_ack    = 1'b0;
    exp_keys  = '0;
    tb_errors = 0;
    stalled   = 1'b0;
    ref_sched = expand_ref(FIPS_KEY);
    if (ref_sched[aes_key_pkg::NUM_ROUNDS] !== FIPS_RK10) begin
      $display("ERROR at %0t: reference round key 10 is %h, expected %h.",
               $time, ref_sched[aes_key_pkg::NUM_ROUNDS], FIPS_RK10);
      tb_errors++;
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    run_request(FIPS_KEY);
    for (int n = 0; n < RANDOM_REQS && !stalled; n++) begin
      rand_key = next_random_key();
      run_request(rand_key);
    end
    repeat (4) @(posedge clk);
    if (!stalled && keys_checked != (RANDOM_REQS + 1) * NUM_KEYS) begin
      $display("Only %0d of %0d round keys were delivered.",
               keys_checked, (RANDOM_REQS + 1) * NUM_KEYS);
      tb_errors++;
    end
    $display("Errors: %0d in the checker, %0d in the testbench, %0d round keys compared.",
             check_errors, tb_errors, keys_checked);
    if (tb_errors == 0 && check_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/aes_key_checker.sv ====
`timescale 1ns/1ps
module aes_key_checker (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic                                                 key_req_i,
  input  logic [aes_key_pkg::KEY_W-1:0]                        key_i,
  input  logic                                                 key_ack_i,
  input  logic                                                 rk_req_i,
  input  logic                                                 rk_ack_i,
  input  logic [aes_key_pkg::KEY_W-1:0]                        rk_key_i,
  input  aes_key_pkg::round_t                                  rk_round_i,
  input  logic [0:aes_key_pkg::NUM_ROUNDS][aes_key_pkg::KEY_W-1:0] exp_keys_i,
  output int                                                   error_count_o,
  output int                                                   keys_checked_o
);

  logic                          prev_rk_req;
  logic                          prev_key_req;
  logic                          prev_key_ack;
  logic                          in_handshake;
  logic [aes_key_pkg::KEY_W-1:0] held_key;
  aes_key_pkg::round_t           held_round;
  int                            round_idx;

  initial begin
    error_count_o  = 0;
    keys_checked_o = 0;
  end

  task automatic flag_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    error_count_o++;
  endtask

  // Outputs are sampled on the falling edge, half a cycle away from any update.
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      if (rk_req_i !== 1'b0 || key_ack_i !== 1'b0 || rk_round_i !== '0 || rk_key_i !== '0) begin
        flag_error("outputs are not cleared during reset.");
      end
      prev_rk_req  = 1'b0;
      prev_key_req = 1'b0;
      prev_key_ack = 1'b0;
      in_handshake = 1'b0;
      round_idx    = 0;
    end else begin
      if (key_req_i && !prev_key_req) begin
        round_idx = 0; // A new key starts a new schedule.
      end
      if (rk_req_i && !prev_rk_req) begin
        if (round_idx > aes_key_pkg::NUM_ROUNDS) begin
          flag_error("round-key request beyond round 10.");
        end else begin
          if (rk_round_i !== aes_key_pkg::round_t'(round_idx)) begin
            flag_error($sformatf("round index is %0d, expected %0d.", rk_round_i, round_idx));
          end
          if (round_idx == 0 && rk_key_i !== key_i) begin
            flag_error($sformatf("round 0 key is %h, the cipher key is %h.",
                                 rk_key_i, key_i));
          end
          if (rk_key_i !== exp_keys_i[round_idx]) begin
            flag_error($sformatf("round %0d key is %h, expected %h.",
                                 round_idx, rk_key_i, exp_keys_i[round_idx]));
          end
        end
        held_key     = rk_key_i;
        held_round   = rk_round_i;
        in_handshake = 1'b1;
        round_idx++;
        keys_checked_o++;
      end else if (in_handshake) begin
        if (rk_key_i !== held_key || rk_round_i !== held_round) begin
          flag_error("round key or index changed before the acknowledge fell.");
        end
      end
      if (in_handshake && !rk_req_i && !rk_ack_i) begin
        in_handshake = 1'b0;
      end
      if (key_ack_i && !prev_key_ack &&
          (round_idx != aes_key_pkg::NUM_ROUNDS + 1 || in_handshake)) begin
        flag_error($sformatf("key acknowledge rose after %0d round keys.", round_idx));
      end
      if (!key_ack_i && prev_key_ack && prev_key_req) begin
        flag_error("key acknowledge fell while the key request was still high.");
      end
      if (rk_req_i && key_ack_i) begin
        flag_error("round-key request and key acknowledge are high together.");
      end
      if (!key_req_i && !key_ack_i && rk_req_i) begin
        flag_error("round-key request is high between key requests.");
      end
      prev_rk_req  = rk_req_i;
      prev_key_req = key_req_i;
      prev_key_ack = key_ack_i;
    end
  end

endmodule

// ==== rtl/aes_key_expand.sv ====
`timescale 1ns/1ps
module aes_key_expand (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          key_req_i,
  input  logic [aes_key_pkg::KEY_W-1:0] key_i,
  output logic                          key_ack_o,
  output logic                          rk_req_o,
  input  logic                          rk_ack_i,
  output logic [aes_key_pkg::KEY_W-1:0] rk_key_o,
  output aes_key_pkg::round_t           rk_round_o
);

  logic               cnt_clr;
  logic               cnt_inc;
  logic               last_round;
  logic               load;
  logic               advance;
  aes_key_pkg::byte_t rcon;

  aes_key_fsm u_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .key_req_i    (key_req_i),
    .key_ack_o    (key_ack_o),
    .rk_req_o     (rk_req_o),
    .rk_ack_i     (rk_ack_i),
    .last_round_i (last_round),
    .cnt_clr_o    (cnt_clr),
    .cnt_inc_o    (cnt_inc),
    .load_o       (load),
    .advance_o    (advance)
  );

  // The counter shows the round of the key that is held, and the constant for the next.
  aes_round_counter u_round_counter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clr_i        (cnt_clr),
    .inc_i        (cnt_inc),
    .round_o      (rk_round_o),
    .rcon_o       (rcon),
    .last_round_o (last_round)
  );

  aes_key_state u_key_state (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_i      (load),
    .advance_i   (advance),
    .key_i       (key_i),
    .rcon_i      (rcon),
    .round_key_o (rk_key_o)
  );

endmodule

// ==== rtl/aes_key_fsm.sv ====
`timescale 1ns/1ps
module aes_key_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic key_req_i,
  output logic key_ack_o,
  output logic rk_req_o,
  input  logic rk_ack_i,
  input  logic last_round_i,
  output logic cnt_clr_o,
  output logic cnt_inc_o,
  output logic load_o,
  output logic advance_o
);

  enum logic [2:0] {IDLE, LOAD, PRESENT, WAIT_ACK_LOW, DONE} state_q, state_d;

  logic rk_req_q;
  logic rk_req_d;
  logic step;

  assign step = (state_q == WAIT_ACK_LOW) && !rk_ack_i; // Consumer has released the key.

  always_comb begin
    state_d  = state_q;
    rk_req_d = rk_req_q;
    case (state_q)
      IDLE: begin
        if (key_req_i) begin
          state_d = LOAD;
        end
      end
      LOAD: begin
        state_d = PRESENT;
      end
      PRESENT: begin
        // The first cycle only sets up the data, so req rises one cycle later.
        if (!rk_req_q) begin
          rk_req_d = 1'b1;
        end else if (rk_ack_i) begin
          rk_req_d = 1'b0;
          state_d  = WAIT_ACK_LOW;
        end
      end
      WAIT_ACK_LOW: begin
        if (step) begin
          state_d = last_round_i ? DONE : PRESENT;
        end
      end
      DONE: begin
        if (!key_req_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      rk_req_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      rk_req_q <= rk_req_d;
    end
  end

  assign load_o    = (state_q == LOAD);
  assign cnt_clr_o = (state_q == LOAD);
  assign advance_o = step && !last_round_i; // Next key is formed while ack is low.
  assign cnt_inc_o = step && !last_round_i;
  assign key_ack_o = (state_q == DONE);
  assign rk_req_o  = rk_req_q;

  a_req_ack_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rk_req_o && key_ack_o));

  // Req only drops once the consumer has answered it.
  a_req_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(rk_req_o) |-> $past(rk_ack_i));

endmodule

// ==== rtl/aes_round_counter.sv ====
`timescale 1ns/1ps
module aes_round_counter (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clr_i,
  input  logic                inc_i,
  output aes_key_pkg::round_t round_o,
  output aes_key_pkg::byte_t  rcon_o,
  output logic                last_round_o
);

  aes_key_pkg::round_t round_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      round_q <= '0;
    end else if (clr_i) begin
      round_q <= '0;
    end else if (inc_i) begin
      round_q <= round_q + aes_key_pkg::round_t'(1);
    end
  end

  assign round_o      = round_q;
  assign last_round_o = (round_q == aes_key_pkg::round_t'(aes_key_pkg::NUM_ROUNDS));

  // Constant for the round that the next advance produces. None exists past the last.
  assign rcon_o = last_round_o ? '0
                               : aes_tables_pkg::RCON[round_q + aes_key_pkg::round_t'(1)];

  a_round_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    round_o <= aes_key_pkg::round_t'(aes_key_pkg::NUM_ROUNDS));

endmodule

// ==== rtl/aes_key_state.sv ====
`timescale 1ns/1ps
module aes_key_state (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              load_i,
  input  logic                              advance_i,
  input  logic [aes_key_pkg::KEY_W-1:0]     key_i,
  input  aes_key_pkg::byte_t                rcon_i,
  output aes_key_pkg::round_key_u           round_key_o
);

  aes_key_pkg::round_key_u key_q;
  aes_key_pkg::round_key_u key_d;
  aes_key_pkg::word_t      last_w;
  aes_key_pkg::word_t      core_w;

  // The S-box path picks up the last four bytes of the current key.
  assign last_w = key_q.bytes[12:15];

  aes_sub_rot_word u_sub_rot_word (
    .word_i (last_w),
    .rcon_i (rcon_i),
    .word_o (core_w)
  );

  always_comb begin
    key_d.words[0] = key_q.words[0] ^ core_w;
    for (int i = 1; i < aes_key_pkg::WORDS_PER_KEY; i++) begin
      key_d.words[i] = key_q.words[i] ^ key_d.words[i-1]; // Chain on the new word.
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q <= '0;
    end else if (load_i) begin
      key_q <= key_i;
    end else if (advance_i) begin
      key_q <= key_d;
    end
  end

  assign round_key_o = key_q;

  a_one_strobe : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(load_i && advance_i));

endmodule

// ==== rtl/aes_sub_rot_word.sv ====
`timescale 1ns/1ps
module aes_sub_rot_word (
  input  aes_key_pkg::word_t word_i,
  input  aes_key_pkg::byte_t rcon_i,
  output aes_key_pkg::word_t word_o
);

  aes_key_pkg::word_t rot_w;
  aes_key_pkg::word_t sub_w;

  // RotWord, the top byte wraps around to the bottom.
  assign rot_w = {word_i[aes_key_pkg::WORD_W-aes_key_pkg::BYTE_W-1:0],
                  word_i[aes_key_pkg::WORD_W-1 -: aes_key_pkg::BYTE_W]};

  always_comb begin
    for (int i = 0; i < aes_key_pkg::WORD_W / aes_key_pkg::BYTE_W; i++) begin
      sub_w[i*aes_key_pkg::BYTE_W +: aes_key_pkg::BYTE_W] =
        aes_tables_pkg::SBOX[rot_w[i*aes_key_pkg::BYTE_W +: aes_key_pkg::BYTE_W]];
    end
  end

  assign word_o = sub_w ^ {rcon_i, {(aes_key_pkg::WORD_W-aes_key_pkg::BYTE_W){1'b0}}};

endmodule

// ==== rtl/aes_tables_pkg.sv ====
package aes_tables_pkg;

  // Forward S-box of FIPS-197, indexed by the input byte.
  localparam aes_key_pkg::byte_t SBOX [0:255] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // Round constants, indexed by the round that they produce.
  localparam aes_key_pkg::byte_t RCON [1:aes_key_pkg::NUM_ROUNDS] = '{
    8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
    8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
  };

endpackage

// ==== rtl/aes_key_pkg.sv ====
package aes_key_pkg;

  localparam int unsigned BYTE_W     = 8;
  localparam int unsigned WORD_W     = 32;
  localparam int unsigned KEY_W      = 128;
  localparam int unsigned ROUND_W    = 4;
  localparam int unsigned NUM_ROUNDS = 10; // Round keys run from 0 to 10.

  localparam int unsigned WORDS_PER_KEY = KEY_W / WORD_W;
  localparam int unsigned BYTES_PER_KEY = KEY_W / BYTE_W;

  typedef logic [BYTE_W-1:0]  byte_t;
  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [ROUND_W-1:0] round_t;

  // One round key, seen as words for the XOR chain or as bytes for the S-box path.
  typedef union packed {
    word_t [0:WORDS_PER_KEY-1] words; // Word 0 holds key bits 127:96.
    byte_t [0:BYTES_PER_KEY-1] bytes; // Byte 0 holds key bits 127:120.
  } round_key_u;

endpackage
